// ==== dv/cpuProbeBoardTb.sv ====
// testbench for the CPU probe board
// drives the CPU bus and buttons, decodes the LCD pins and checks every response
`default_nettype none
`include "board_defs.svh"

module cpuProbeBoardTb;

    import busPkg::*;
    import lcdPkg::*;

    localparam int clkPeriod  = 40;
    localparam int deb        = `DEBOUNCE_CYCLES;
    localparam int numWrites  = 40;
    localparam int byteClks   = 4 * `LCD_E_WIDTH + `LCD_CMD_WAIT + 4;
    localparam int settleClks = 4 * byteClks;
    localparam int initClks   = `LCD_POWER_WAIT + 4 * (2 * `LCD_E_WIDTH + `LCD_CMD_WAIT)
                                + 4 * byteClks + 8;
    localparam int memClks    = 2 * numWrites * (2 * `PHASE_DIV + 4);
    localparam int pressClks  = 6 * deb + 3 * byteClks + settleClks;
    localparam int totalClks  = 10 + 12 * `PHASE_DIV + initClks + memClks + 5 * pressClks;

    logic       userClk;
    logic       arstN;
    cpuBusT     bus;
    logic [7:0] busRData;
    logic       phi0;
    logic       phi0Rise;
    logic       showButton;
    logic       clearButton;
    logic [7:0] leds;
    logic       initLed;
    lcdPinsT    lcd;

    int          seed = 92;
    logic [7:0]  model [1 << `MEM_ADDR_BITS];   // expected memory contents
    logic [15:0] writtenAddrs [$];
    logic [8:0]  lcdQ [$];                      // {rs, byte} as seen on the pins
    int          lcdRead = 0;

    cpuProbeBoard uut (
        .userClk, .arstN, .bus, .busRData, .phi0, .phi0Rise,
        .showButton, .clearButton, .leds, .initLed, .lcd
    );

    initial begin
        userClk = 1'b0;
        forever #(clkPeriod / 2) userClk = ~userClk;
    end

    task automatic stopWithError(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stopWithError($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic checkByte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            stopWithError($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic checkPins(input string name, input lcdPinsT got, input lcdPinsT exp);
        if (got !== exp) begin
            stopWithError($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    // next decoded LCD byte, waits for it if the display has not got it yet
    task automatic checkLcdByte(input logic expRs, input logic [7:0] expByte);
        logic [8:0] item;
        while (lcdRead >= lcdQ.size()) @(negedge userClk);
        item = lcdQ[lcdRead];
        lcdRead++;
        if (item !== {expRs, expByte}) begin
            stopWithError($sformatf("Mismatch lcd {rs,byte}: got 0x%h, expected 0x%h",
                                    item, {expRs, expByte}));
        end
    endtask

    function automatic logic [31:0] nextRandom();
        return $random(seed);
    endfunction

    function automatic logic [7:0] hexChar(input logic [3:0] nib);
        string digits;
        digits = "0123456789ABCDEF";
        return digits[int'(nib)];
    endfunction

    // the display latches db on the falling edge of e
    initial begin : lcdMonitor
        logic       prevE;
        logic       haveHi;
        logic       hiRs;
        logic [3:0] hiNib;
        int         wakeNibbles;
        prevE       = 1'b0;
        haveHi      = 1'b0;
        wakeNibbles = 0;
        forever begin
            @(negedge userClk);
            if (prevE && !lcd.e) begin
                checkBit("lcd.rw", lcd.rw, 1'b0);
                if (wakeNibbles < 4) begin
                    lcdQ.push_back({lcd.rs, lcd.db, 4'h0});   // still 8-bit mode, one nibble each
                    wakeNibbles++;
                end else if (!haveHi) begin
                    hiNib  = lcd.db;
                    hiRs   = lcd.rs;
                    haveHi = 1'b1;
                end else begin
                    checkBit("lcd.rs", lcd.rs, hiRs);   // both halves of a byte share rs
                    lcdQ.push_back({lcd.rs, hiNib, lcd.db});
                    haveHi = 1'b0;
                end
            end
            prevE = lcd.e;
        end
    end

    initial begin : watchdog
        #(2 * totalClks * clkPeriod);
        stopWithError("Timeout: the tests did not finish in the expected time");
    end

    task automatic waitPhaseChange(output int cnt);
        logic prev;
        prev = phi0;
        cnt  = 0;
        do begin
            @(negedge userClk);
            cnt++;
            checkBit("phi0Rise", phi0Rise, phi0 && !prev);   // one cycle, with the rising level
        end while (phi0 == prev);
    endtask

    task automatic testPhase();
        int cnt;
        checkBit("phi0", phi0, 1'b0);
        checkBit("initLed", initLed, 1'b0);
        checkPins("lcd", lcd, '0);
        for (int k = 0; k < 5; k++) begin
            waitPhaseChange(cnt);
            checkByte("phi0 half period", cnt[7:0], 8'(`PHASE_DIV));
        end
    endtask

    task automatic testInit();
        lcdCmdT initCmds [4];
        initCmds = '{funcSet4Bit, displayOn, entryMode, clearDisplay};
        for (int k = 0; k < 3; k++) checkLcdByte(1'b0, 8'h30);
        checkLcdByte(1'b0, 8'h20);
        for (int k = 0; k < 4; k++) checkLcdByte(1'b0, initCmds[k]);
        checkBit("initLed", initLed, 1'b0);   // last command still settling
        while (!initLed) @(negedge userClk);
    endtask

    task automatic writeBus(input cpuBusT wr);
        @(negedge userClk);
        while (!phi0Rise) @(negedge userClk);
        bus = wr;   // written on the next rising clock
        @(negedge userClk);
        checkByte("leds", leds, wr.addr[7:0]);
        model[wr.addr[`MEM_ADDR_BITS-1:0]] = wr.wData;
    endtask

    task automatic readBus(input logic [15:0] addr, input logic [7:0] expData);
        @(negedge userClk);
        bus.addr  = addr;
        bus.wData = '0;
        bus.rw    = 1'b1;
        @(negedge userClk);
        checkByte("leds", leds, addr[7:0]);
        checkByte("busRData", busRData, expData);
    endtask

    task automatic testMemory();
        cpuBusT      wr;
        logic [31:0] rnd;
        logic [15:0] a;
        for (int k = 0; k < numWrites; k++) begin
            rnd          = nextRandom();
            wr.addr      = rnd[15:0];
            wr.addr[7:5] = '0;   // few slots, so later writes overwrite earlier ones
            wr.wData     = rnd[23:16];
            wr.rw        = 1'b0;
            writeBus(wr);
            readBus(wr.addr, wr.wData);
            writtenAddrs.push_back(wr.addr);
        end
        foreach (writtenAddrs[k]) begin
            rnd = nextRandom();
            a   = writtenAddrs[k];
            readBus({rnd[7:0], a[7:0]}, model[a[`MEM_ADDR_BITS-1:0]]);   // aliased upper byte
        end
    endtask

    task automatic pressButton(input logic isClear, input logic bounce);
        logic level;
        for (int i = 0; i < 6 * deb; i++) begin
            @(negedge userClk);
            level = (i < 3 * deb);
            if (bounce && (i % (3 * deb)) < 6) level = i[0];   // contact chatter
            if (isClear) clearButton = level;
            else showButton = level;
        end
    endtask

    task automatic expectLcdQuiet();
        repeat (settleClks) @(negedge userClk);
        if (lcdRead != lcdQ.size()) stopWithError("LCD got an unexpected extra byte");
    endtask

    task automatic testShow(input logic readCycle, input logic bounce);
        cpuBusT      b;
        logic [31:0] rnd;
        logic [15:0] a;
        logic [7:0]  shown;
        rnd = nextRandom();
        a   = writtenAddrs[0];
        if (readCycle) begin
            b.addr  = {rnd[15:8], a[7:0]};
            b.wData = '0;
        end else begin
            b.addr      = rnd[15:0];
            b.addr[7:5] = '0;
            b.wData     = rnd[23:16];
        end
        b.rw = readCycle;
        @(negedge userClk);
        bus   = b;
        shown = readCycle ? model[b.addr[`MEM_ADDR_BITS-1:0]] : b.wData;
        pressButton(1'b0, bounce);
        checkByte("leds", leds, b.addr[7:0]);
        checkLcdByte(1'b1, hexChar(shown[7:4]));
        checkLcdByte(1'b1, hexChar(shown[3:0]));
        if (!readCycle) model[b.addr[`MEM_ADDR_BITS-1:0]] = b.wData;
        expectLcdQuiet();
        bus.rw = 1'b1;
    endtask

    task automatic testClear();
        pressButton(1'b1, 1'b0);
        checkLcdByte(1'b0, clearDisplay);
        expectLcdQuiet();
    endtask

    task automatic testClearDuringWrite();
        cpuBusT      b;
        logic [31:0] rnd;
        rnd         = nextRandom();
        b.addr      = rnd[15:0];
        b.addr[7:5] = '0;
        b.wData     = rnd[23:16];
        b.rw        = 1'b0;
        @(negedge userClk);
        bus = b;
        for (int i = 0; i < 6 * deb; i++) begin
            @(negedge userClk);
            showButton  = (i < 3 * deb);
            clearButton = (i >= deb + 4) && (i < 4 * deb + 4);   // lands in the first character
        end
        checkLcdByte(1'b1, hexChar(b.wData[7:4]));
        checkLcdByte(1'b1, hexChar(b.wData[3:0]));
        checkLcdByte(1'b0, clearDisplay);
        model[b.addr[`MEM_ADDR_BITS-1:0]] = b.wData;
        expectLcdQuiet();
        bus.rw = 1'b1;
    endtask

    initial begin
        arstN       = 1'b0;
        bus         = '0;
        bus.rw      = 1'b1;
        showButton  = 1'b0;
        clearButton = 1'b0;
        repeat (10) @(negedge userClk);
        arstN = 1'b1;

        testPhase();
        testInit();
        testMemory();
        testShow(1'b0, 1'b0);
        testShow(1'b1, 1'b0);
        testShow(1'b0, 1'b1);
        testClear();
        testClearDuringWrite();

        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build the CPU probe board testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module cpuProbeBoardTb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/VcpuProbeBoardTb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

printf '%s\n' "$out" | grep -qx '>>> PASS' || exit 1
exit 0

// ==== src.f ====
+incdir+src
src/busPkg.sv
src/lcdPkg.sv
src/phaseClockGen.sv
src/buttonDebounce.sv
src/probeMemory.sv
src/hexByteWriter.sv
src/lcdController.sv
src/cpuProbeBoard.sv
dv/cpuProbeBoardTb.sv

// ==== src/board_defs.svh ====
// timing and sizing constants for the CPU probe harness
// values here are the short simulation counts; modules take them as parameter defaults
`ifndef BOARD_DEFS_SVH
`define BOARD_DEFS_SVH

// board clocks in half a CPU phase period
`define PHASE_DIV 4

// clocks a button level must hold before it is accepted
`define DEBOUNCE_CYCLES 8

// LCD power-up wait before the first init nibble
`define LCD_POWER_WAIT 64

// settle time after every LCD byte or init nibble
`define LCD_CMD_WAIT 16

// enable high time, and again the low time, per nibble
`define LCD_E_WIDTH 4

// probe memory depth as address bits, aliased over the 16-bit bus
`define MEM_ADDR_BITS 8

`endif

// ==== src/busPkg.sv ====
// CPU bus types
// one bus cycle as driven by the external core, and the view shown on the board
`default_nettype none

package busPkg;

    // one CPU bus cycle
    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  wData;   // valid when rw is low
        logic        rw;      // 1 = read, 0 = write
    } cpuBusT;

    // what the harness shows on LEDs and LCD
    typedef struct packed {
        logic [7:0] addrLow;
        logic [7:0] dataByte;   // byte on the data bus this cycle
    } busViewT;

endpackage

`default_nettype wire

// ==== src/buttonDebounce.sv ====
// push button debouncer
// 2-flop synchroniser, stable-count filter, one pulse per accepted press
`default_nettype none
`include "board_defs.svh"

module buttonDebounce #(
    parameter int debounceCycles = `DEBOUNCE_CYCLES
) (
    input  wire logic userClk,
    input  wire logic arstN,
    input  wire logic button,
    output logic      press
);

    localparam int cntW = $clog2(debounceCycles + 1);
    localparam logic [cntW-1:0] lastCnt = cntW'(debounceCycles - 1);

    logic [1:0]      syncQ;
    logic            level;    // accepted button level
    logic            levelQ;
    logic [cntW-1:0] stableCnt;

    always_ff @(posedge userClk or negedge arstN) begin
        if (!arstN) begin
            syncQ     <= '0;
            level     <= 1'b0;
            levelQ    <= 1'b0;
            stableCnt <= '0;
            press     <= 1'b0;
        end else begin
            syncQ <= {syncQ[0], button};
            if (syncQ[1] == level) begin
                stableCnt <= '0;   // any bounce restarts the count
            end else if (stableCnt == lastCnt) begin
                stableCnt <= '0;
                level     <= syncQ[1];
            end else begin
                stableCnt <= stableCnt + 1'b1;
            end
            levelQ <= level;
            press  <= level & ~levelQ;   // release gives nothing
        end
    end

endmodule

`default_nettype wire

// ==== src/cpuProbeBoard.sv ====
// CPU probe board top level
// phase clock, bus memory, LED view and button-driven hex dump to the LCD
`default_nettype none

module cpuProbeBoard (
    input  wire logic           userClk,
    input  wire logic           arstN,
    input  wire busPkg::cpuBusT bus,
    output logic [7:0]          busRData,
    output logic                phi0,
    output logic                phi0Rise,
    input  wire logic           showButton,
    input  wire logic           clearButton,
    output logic [7:0]          leds,
    output logic                initLed,
    output lcdPkg::lcdPinsT     lcd
);

    import busPkg::*;

    busViewT    view;
    logic       showPulse;
    logic       clearPulse;
    logic       initDone;
    logic       writeStart;
    logic       writeDone;
    logic [7:0] charData;

    // the memory drives the data bus on reads, the CPU on writes
    assign view.addrLow  = bus.addr[7:0];
    assign view.dataByte = bus.rw ? busRData : bus.wData;
    assign leds          = view.addrLow;
    assign initLed       = initDone;

    phaseClockGen phaseGen (.userClk, .arstN, .phi0, .phi0Rise);

    buttonDebounce showDeb (.userClk, .arstN, .button(showButton), .press(showPulse));

    buttonDebounce clearDeb (.userClk, .arstN, .button(clearButton), .press(clearPulse));

    probeMemory mem (.userClk, .arstN, .bus, .phi0Rise, .rData(busRData));

    hexByteWriter hexWriter (
        .userClk, .arstN,
        .show     (showPulse),
        .dataByte (view.dataByte),
        .initDone, .writeDone, .writeStart, .charData
    );

    lcdController lcdCtrl (
        .userClk, .arstN, .writeStart, .charData,
        .clearAll (clearPulse),
        .initDone, .writeDone,
        .pins     (lcd)
    );

endmodule

`default_nettype wire

// ==== src/hexByteWriter.sv ====
// hex byte writer
// latches a bus byte on a press and sends it to the LCD as two ASCII hex digits
`default_nettype none

module hexByteWriter (
    input  wire logic  userClk,
    input  wire logic  arstN,
    input  wire logic  show,
    input  wire logic [7:0] dataByte,
    input  wire logic  initDone,
    input  wire logic  writeDone,
    output logic       writeStart,
    output logic [7:0] charData
);

    import lcdPkg::*;

    hexStateT   state;
    logic [3:0] loNibble;   // second digit waits here

    function automatic logic [7:0] hexAscii(input logic [3:0] nib);
        logic [7:0] wide;
        wide = {4'h0, nib};
        if (nib < 4'd10) begin
            return 8'h30 + wide;   // '0'..'9'
        end
        return 8'h37 + wide;       // 'A'..'F'
    endfunction

    always_ff @(posedge userClk or negedge arstN) begin
        if (!arstN) begin
            state      <= hexIdle;
            writeStart <= 1'b0;
            charData   <= '0;
            loNibble   <= '0;
        end else begin
            writeStart <= 1'b0;
            case (state)
                hexIdle: if (show && initDone) begin   // presses while busy are dropped
                    loNibble   <= dataByte[3:0];
                    charData   <= hexAscii(dataByte[7:4]);
                    writeStart <= 1'b1;
                    state      <= sendHi;
                end
                sendHi: state <= waitHi;
                waitHi: if (writeDone) begin
                    charData   <= hexAscii(loNibble);
                    writeStart <= 1'b1;
                    state      <= sendLo;
                end
                sendLo: state <= waitLo;
                waitLo: if (writeDone) begin
                    state <= hexIdle;
                end
                default: state <= hexIdle;
            endcase
        end
    end

    startInSend: assert property (@(posedge userClk) disable iff (!arstN)
        writeStart |-> state inside {sendHi, sendLo});

    // controller only reports completion of a character this block started
    doneWhileWaiting: assert property (@(posedge userClk) disable iff (!arstN)
        writeDone |-> state inside {waitHi, waitLo});

endmodule

`default_nettype wire

// ==== src/lcdController.sv ====
// HD44780 LCD controller, 4-bit mode
// timed power-up init, then character writes and clear commands as strobed nibbles
`default_nettype none
`include "board_defs.svh"

module lcdController #(
    parameter int lcdPowerWait = `LCD_POWER_WAIT,
    parameter int lcdCmdWait   = `LCD_CMD_WAIT,
    parameter int lcdEWidth    = `LCD_E_WIDTH
) (
    input  wire logic       userClk,
    input  wire logic       arstN,
    input  wire logic       writeStart,
    input  wire logic [7:0] charData,
    input  wire logic       clearAll,
    output logic            initDone,
    output logic            writeDone,
    output lcdPkg::lcdPinsT pins
);

    import lcdPkg::*;

    localparam int longest  = (lcdPowerWait > lcdCmdWait) ? lcdPowerWait : lcdCmdWait;
    localparam int maxCount = (longest > 2 * lcdEWidth) ? longest : 2 * lcdEWidth;
    localparam int timerW   = $clog2(maxCount + 1);
    localparam logic [timerW-1:0] powerLast = timerW'(lcdPowerWait - 1);
    localparam logic [timerW-1:0] cmdLast   = timerW'(lcdCmdWait - 1);
    localparam logic [timerW-1:0] eLast     = timerW'(lcdEWidth - 1);
    localparam logic [timerW-1:0] nibLast   = timerW'(2 * lcdEWidth - 1);

    lcdStateT          state;
    logic [timerW-1:0] timer;
    logic [2:0]        step;      // init sequence position, 0..3 nibbles, 4..7 bytes
    logic [7:0]        byteReg;
    logic              rsReg;
    logic              eReg;
    logic              clearPend;
    logic              charPend;  // character that arrived during a clear
    logic [7:0]        charReg;

    function automatic logic [7:0] initByte(input logic [2:0] idx);
        lcdCmdT cmd;
        case (idx)
            3'd4:    cmd = funcSet4Bit;
            3'd5:    cmd = displayOn;
            3'd6:    cmd = entryMode;
            default: cmd = clearDisplay;
        endcase
        return cmd;
    endfunction

    always_ff @(posedge userClk or negedge arstN) begin
        if (!arstN) begin
            state     <= powerWait;
            timer     <= '0;
            step      <= '0;
            byteReg   <= '0;
            rsReg     <= 1'b0;
            eReg      <= 1'b0;
            initDone  <= 1'b0;
            writeDone <= 1'b0;
            clearPend <= 1'b0;
            charPend  <= 1'b0;
            charReg   <= '0;
        end else begin
            writeDone <= 1'b0;
            if (clearAll) clearPend <= 1'b1;
            if (writeStart) begin
                charPend <= 1'b1;
                charReg  <= charData;
            end
            case (state)
                powerWait: if (timer == powerLast) begin
                    timer <= '0;
                    eReg  <= 1'b1;
                    state <= initNibble;
                end else begin
                    timer <= timer + 1'b1;
                end
                initNibble, sendHigh, sendLow: begin
                    if (timer == eLast) eReg <= 1'b0;
                    if (timer == nibLast) begin
                        timer <= '0;
                        if (state == sendHigh) begin
                            eReg  <= 1'b1;
                            state <= sendLow;
                        end else begin
                            state <= cmdWait;
                        end
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                cmdWait: if (timer == cmdLast) begin
                    timer <= '0;
                    if (initDone) begin
                        state     <= idle;
                        writeDone <= rsReg;   // commands finish without a done pulse
                    end else if (step == 3'd7) begin
                        initDone <= 1'b1;
                        state    <= idle;
                    end else begin
                        step <= step + 1'b1;
                        eReg <= 1'b1;
                        if (step < 3'd3) begin
                            state <= initNibble;
                        end else begin
                            byteReg <= initByte(step + 3'd1);
                            state   <= sendHigh;
                        end
                    end
                end else begin
                    timer <= timer + 1'b1;
                end
                idle: if (writeStart || charPend) begin   // characters go before a pending clear
                    byteReg  <= writeStart ? charData : charReg;
                    rsReg    <= 1'b1;
                    charPend <= 1'b0;
                    eReg     <= 1'b1;
                    state    <= sendHigh;
                end else if (clearPend && !writeDone) begin   // writer gets its next digit first
                    byteReg   <= clearDisplay;
                    rsReg     <= 1'b0;
                    clearPend <= 1'b0;
                    eReg      <= 1'b1;
                    state     <= sendHigh;
                end
                default: state <= powerWait;
            endcase
        end
    end

    always_comb begin
        pins.rs = rsReg;
        pins.rw = 1'b0;   // write only, busy flag never polled
        pins.e  = eReg;
        case (state)
            initNibble: pins.db = (step == 3'd3) ? 4'h2 : 4'h3;
            sendLow:    pins.db = byteReg[3:0];
            default:    pins.db = byteReg[7:4];
        endcase
    end

    dbStableWhileE: assert property (@(posedge userClk) disable iff (!arstN)
        pins.e && $past(pins.e) |-> $stable(pins.db) && $stable(pins.rs));

    // writer must not start before init has finished
    startAfterInit: assert property (@(posedge userClk) disable iff (!arstN)
        writeStart |-> initDone);

endmodule

`default_nettype wire

// ==== src/lcdPkg.sv ====
// LCD types
// pin bundle, controller and hex writer states, and HD44780 opcodes
`default_nettype none

package lcdPkg;

    // 4-bit HD44780 interface pins
    typedef struct packed {
        logic       rs;   // 1 = character, 0 = command
        logic       rw;
        logic       e;
        logic [3:0] db;   // DB7..DB4
    } lcdPinsT;

    typedef enum logic [2:0] {
        powerWait,
        initNibble,
        idle,
        sendHigh,
        sendLow,
        cmdWait
    } lcdStateT;

    typedef enum logic [2:0] {
        hexIdle,
        sendHi,
        waitHi,
        sendLo,
        waitLo
    } hexStateT;

    typedef enum logic [7:0] {
        funcSet4Bit  = 8'h28,   // 4-bit bus, 2 lines, 5x8 font
        entryMode    = 8'h06,   // increment, no shift
        displayOn    = 8'h0C,   // display on, cursor off
        clearDisplay = 8'h01
    } lcdCmdT;

endpackage

`default_nettype wire

// ==== src/phaseClockGen.sv ====
// CPU phase generator
// divides the board clock into a phase level and a one-cycle rising strobe
`default_nettype none
`include "board_defs.svh"

module phaseClockGen #(
    parameter int phaseDiv = `PHASE_DIV
) (
    input  wire logic userClk,
    input  wire logic arstN,
    output logic      phi0,
    output logic      phi0Rise
);

    localparam int cntW = $clog2(phaseDiv + 1);
    localparam logic [cntW-1:0] lastCnt = cntW'(phaseDiv - 1);

    logic [cntW-1:0] divCnt;

    // clock-enable style divider, no derived clock leaves this block
    always_ff @(posedge userClk or negedge arstN) begin
        if (!arstN) begin
            divCnt   <= '0;
            phi0     <= 1'b0;
            phi0Rise <= 1'b0;
        end else if (divCnt == lastCnt) begin
            divCnt   <= '0;
            phi0     <= ~phi0;
            phi0Rise <= ~phi0;   // strobe lands together with the new high level
        end else begin
            divCnt   <= divCnt + 1'b1;
            phi0Rise <= 1'b0;
        end
    end

    // strobe only in the first cycle of a high phase
    riseOnEdge: assert property (@(posedge userClk) disable iff (!arstN)
        phi0Rise |-> phi0 && !$past(phi0));

endmodule

`default_nettype wire

// ==== src/probeMemory.sv ====
// probe memory
// small byte RAM on the CPU bus, written at the phase strobe, read every clock
`default_nettype none
`include "board_defs.svh"

module probeMemory #(
    parameter int addrBits = `MEM_ADDR_BITS
) (
    input  wire logic           userClk,
    input  wire logic           arstN,
    input  wire busPkg::cpuBusT bus,
    input  wire logic           phi0Rise,
    output logic [7:0]          rData
);

    localparam int depth = 1 << addrBits;

    logic [7:0]          mem [depth];
    logic [addrBits-1:0] idx;

    assign idx = bus.addr[addrBits-1:0];   // upper address bits alias

    // one write per phase, only on CPU write cycles
    always_ff @(posedge userClk) begin
        if (phi0Rise && !bus.rw) begin
            mem[idx] <= bus.wData;
        end
    end

    // read port, old word if written on the same edge
    always_ff @(posedge userClk or negedge arstN) begin
        if (!arstN) begin
            rData <= '0;
        end else begin
            rData <= mem[idx];
        end
    end

endmodule

`default_nettype wire
